// File: Bender.yml
package:
  name: ac97ctrl

sources:
  - common/ac97_pkg.sv
  - src/ac97_sample_tick.sv
  - src/ac97_sample_fifo.sv
  - src/ac97_frame_port.sv
  - src/ac97_codec_regs.sv
  - bus/ac97_bus_regs.sv
  - src/ac97ctrl_top.sv
  - target: test
    files:
      - sim/tb_ac97ctrl.sv

// File: bus/ac97_bus_regs.sv
// register decoder of the bridge, pairs play samples, unpairs record samples, holds status
`timescale 1ns/100ps
`default_nettype none

module ac97_bus_regs (
  input  logic                              clk_adc_125mhz,
  input  logic                              adc_rstn_i,
  input  ac97_pkg::bus_req_t                bus_req_i,
  output ac97_pkg::bus_rsp_t                bus_rsp_o,
  output logic                              play_push_valid_o,
  output ac97_pkg::sample_pair_t            play_push_data_o,
  input  logic                              play_push_ready_i,
  output logic                              play_flush_o,
  output logic                              rec_flush_o,
  input  ac97_pkg::sample_pair_t            rec_head_i,
  output logic                              rec_pop_o,
  input  logic                              play_full_i,
  input  logic                              play_half_empty_i,
  input  logic                              rec_full_i,
  input  logic                              rec_empty_i,
  input  logic                              access_done_i,
  input  logic                              underrun_i,
  input  logic                              overrun_i,
  output logic                              codec_store_o,
  output logic                              codec_recall_o,
  output logic                              codec_addr_write_o,
  output logic [ac97_pkg::CODEC_ADDR_W-1:0] codec_index_o,
  output logic [ac97_pkg::SAMPLE_W-1:0]     codec_wdata_o,
  input  logic [ac97_pkg::SAMPLE_W-1:0]     codec_rdata_i
);

  import ac97_pkg::*;

  localparam int HOLD_W = $clog2(STARTUP_CYCLES + 1);

  logic [HOLD_W-1:0]     hold_ctr;
  logic                  hold, codec_ready;
  logic                  play_is_right, rec_is_right;  // pair phases
  logic [SAMPLE_W-1:0]   play_left;
  logic                  wr_play, wr_reset, wr_cwdata, rd_rec;
  logic [7:0]            status;
  logic [BUS_DATA_W-1:0] rd_mux;

  // ---------------------------------------------------------------------------
  // access decode
  // ---------------------------------------------------------------------------
  assign wr_play            = bus_req_i.wen && (bus_req_i.addr == PLAY_DATA);
  assign wr_reset           = bus_req_i.wen && (bus_req_i.addr == FIFO_RESET);
  assign wr_cwdata          = bus_req_i.wen && (bus_req_i.addr == CODEC_WDATA);
  assign rd_rec             = bus_req_i.ren && (bus_req_i.addr == REC_DATA);
  assign codec_addr_write_o = bus_req_i.wen && (bus_req_i.addr == CODEC_ADDR);
  assign codec_store_o      = codec_addr_write_o && !bus_req_i.wdata[7];
  assign codec_recall_o     = codec_addr_write_o && bus_req_i.wdata[7];
  assign codec_index_o      = bus_req_i.wdata[6:1];

  assign play_flush_o       = hold || (wr_reset && bus_req_i.wdata[0]);
  assign rec_flush_o        = hold || (wr_reset && bus_req_i.wdata[1]);

  assign play_push_valid_o  = wr_play && play_is_right;  // dropped if not ready
  assign play_push_data_o   = '{right: bus_req_i.wdata[SAMPLE_W-1:0], left: play_left};
  assign rec_pop_o          = rd_rec && rec_is_right;    // right read pops

  // ---------------------------------------------------------------------------
  // start-up hold and pair phases
  // ---------------------------------------------------------------------------
  assign hold = (hold_ctr != '0);

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      hold_ctr      <= HOLD_W'(STARTUP_CYCLES);
      codec_ready   <= 1'b0;
      play_is_right <= 1'b0;
      rec_is_right  <= 1'b0;
    end else begin
      if (hold) hold_ctr <= hold_ctr - 1'b1;
      codec_ready <= !hold;
      if (play_flush_o) play_is_right <= 1'b0;
      else if (wr_play) play_is_right <= !play_is_right;
      if (rec_flush_o)  rec_is_right  <= 1'b0;
      else if (rd_rec)  rec_is_right  <= !rec_is_right;
    end
  end

  always_ff @(posedge clk_adc_125mhz) begin
    if (wr_play && !play_is_right) play_left <= bus_req_i.wdata[SAMPLE_W-1:0];
    if (wr_cwdata) codec_wdata_o <= bus_req_i.wdata[SAMPLE_W-1:0];
  end

  // ---------------------------------------------------------------------------
  // read mux and response
  // ---------------------------------------------------------------------------
  always_comb begin
    status                  = '0;
    status[PLAY_FULL]       = play_full_i;
    status[PLAY_HALF_EMPTY] = play_half_empty_i;
    status[REC_FULL]        = rec_full_i;
    status[REC_EMPTY]       = rec_empty_i;
    status[ACCESS_DONE]     = access_done_i;
    status[CODEC_READY]     = codec_ready;
    status[PLAY_UNDERRUN]   = underrun_i;
    status[REC_OVERRUN]     = overrun_i;
  end

  always_comb begin
    rd_mux = '0;                                 // unmapped and write-only
    case (bus_req_i.addr)
      REC_DATA: begin
        if (!rec_empty_i) begin
          rd_mux = BUS_DATA_W'(rec_is_right ? rec_head_i.right : rec_head_i.left);
        end
      end
      STATUS:      rd_mux = BUS_DATA_W'(status);
      CODEC_RDATA: rd_mux = BUS_DATA_W'(codec_rdata_i);
      default:     rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      bus_rsp_o <= '0;
    end else begin
      bus_rsp_o.ack   <= bus_req_i.wen || bus_req_i.ren;  // one cycle later
      bus_rsp_o.rdata <= bus_req_i.ren ? rd_mux : '0;
    end
  end

  a_one_access : assert property (@(posedge clk_adc_125mhz) disable iff (!adc_rstn_i)
    !(bus_req_i.wen && bus_req_i.ren))
    else $error("bus write and read in the same cycle");

endmodule

`default_nettype wire

// File: common/ac97_pkg.sv
// shared types and constants of the audio sample bridge, imported by every block
`default_nettype none

package ac97_pkg;

  // ---------------------------------------------------------------------------
  // widths and timing constants
  // ---------------------------------------------------------------------------
  localparam int SAMPLE_W       = 16;  // one audio sample
  localparam int BUS_DATA_W     = 32;  // bus data word
  localparam int BUS_ADDR_W     = 20;  // decoded address bits
  localparam int CODEC_ADDR_W   = 6;   // 64 codec registers
  localparam int STARTUP_CYCLES = 4;   // hold after reset

  typedef struct packed {
    logic [SAMPLE_W-1:0] right;        // upper half of the word
    logic [SAMPLE_W-1:0] left;         // lower half of the word
  } sample_pair_t;

  typedef struct packed {
    logic [BUS_ADDR_W-1:0] addr;
    logic [BUS_DATA_W-1:0] wdata;
    logic                  wen;        // single cycle
    logic                  ren;        // single cycle
  } bus_req_t;

  typedef struct packed {
    logic [BUS_DATA_W-1:0] rdata;      // valid with ack
    logic                  ack;
  } bus_rsp_t;

  // ---------------------------------------------------------------------------
  // register map and status word layout
  // ---------------------------------------------------------------------------
  typedef enum logic [BUS_ADDR_W-1:0] {
    PLAY_DATA   = 20'h00000,           // write left, then right
    REC_DATA    = 20'h00004,           // read left, then right
    STATUS      = 20'h00008,
    FIFO_RESET  = 20'h0000C,           // bit 0 play, bit 1 record
    CODEC_ADDR  = 20'h00010,           // bit 7 recall, bits 6:1 index
    CODEC_RDATA = 20'h00014,
    CODEC_WDATA = 20'h00018
  } reg_addr_e;

  typedef enum logic [2:0] {
    PLAY_FULL, PLAY_HALF_EMPTY, REC_FULL, REC_EMPTY,
    ACCESS_DONE, CODEC_READY, PLAY_UNDERRUN, REC_OVERRUN
  } stat_bit_e;

  typedef enum logic [2:0] {
    NONE,                              // never
    EMPTY,                             // count == 0
    HALF_EMPTY,                        // count <= depth/2 - 1
    HALF_FULL,                         // count >= depth/2
    FULL                               // count == depth
  } irq_level_e;

endpackage

`default_nettype wire

// File: project.f
common/ac97_pkg.sv
src/ac97_sample_tick.sv
src/ac97_sample_fifo.sv
src/ac97_frame_port.sv
src/ac97_codec_regs.sv
bus/ac97_bus_regs.sv
src/ac97ctrl_top.sv
sim/tb_ac97ctrl.sv

// File: sim/tb_ac97ctrl.sv
// directed testbench of the audio sample bridge, run as the simulation top with project.f
`timescale 1ns/100ps
`default_nettype none

module tb_ac97ctrl;

  import ac97_pkg::*;

  localparam int          CTR_MAX        = 40;            // short tick interval
  localparam int          FRC_MAX        = 5;             // one long run every 6 ticks
  localparam int          FIFO_DEPTH     = 16;
  localparam int          RESET_CYCLES   = 4;
  localparam int          TIMEOUT_CYCLES = 6000;          // ~110 ticks of 41 plus margin
  localparam logic [31:0] SEED           = 32'h8aab6f65;

  logic         clk_adc_125mhz;
  logic         adc_rstn;
  bus_req_t     bus_req;
  bus_rsp_t     bus_rsp;
  sample_pair_t line_in, line_out;
  logic         sample_tick, irq_play, irq_rec;

  sample_pair_t play_q [$];                               // pairs written for playback
  sample_pair_t rec_q [$];                                // pairs the record FIFO should hold
  logic         rec_model_en = 1'b0;
  int           errors = 0;
  int           checks = 0;
  int           cycles = 0;

  ac97ctrl_top #(
    .FIFO_DEPTH     (FIFO_DEPTH),
    .TICK_CTR_MAX   (CTR_MAX),
    .TICK_FRC_MAX   (FRC_MAX),
    .PLAY_IRQ_LEVEL (HALF_EMPTY),
    .REC_IRQ_LEVEL  (HALF_FULL)
  ) i_dut (
    .clk_adc_125mhz (clk_adc_125mhz),
    .adc_rstn_i     (adc_rstn),
    .bus_req_i      (bus_req),
    .bus_rsp_o      (bus_rsp),
    .line_in_i      (line_in),
    .line_out_o     (line_out),
    .sample_tick_o  (sample_tick),
    .irq_play_o     (irq_play),
    .irq_rec_o      (irq_rec)
  );

  initial begin
    clk_adc_125mhz = 1'b0;
    forever #4 clk_adc_125mhz = ~clk_adc_125mhz;          // 8 ns period
  end

  // ----------------------------------------------------------------------------
  // line input source and record model, both move on the tick
  // ----------------------------------------------------------------------------
  always @(posedge clk_adc_125mhz) begin
    if (sample_tick) begin
      if (rec_model_en) begin
        if (rec_q.size() < FIFO_DEPTH) rec_q.push_back(line_in);  // full FIFO loses it
      end
      line_in <= sample_pair_t'($urandom);
    end
  end

  always @(posedge clk_adc_125mhz) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run stopped after %0d cycles without finishing the tests", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  // ----------------------------------------------------------------------------
  // bus access and check helpers
  // ----------------------------------------------------------------------------
  task automatic check_equal(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic bus_write(input logic [BUS_ADDR_W-1:0] addr, input logic [BUS_DATA_W-1:0] data);
    @(posedge clk_adc_125mhz);
    bus_req.addr  <= addr;
    bus_req.wdata <= data;
    bus_req.wen   <= 1'b1;
    @(posedge clk_adc_125mhz);
    bus_req.wen   <= 1'b0;
    @(negedge clk_adc_125mhz);                            // ack one cycle after the access
    checks++;
    assert (bus_rsp.ack) else begin
      errors++;
      $display("no bus acknowledge for the write to offset %h", addr);
    end
  endtask

  task automatic bus_read(input logic [BUS_ADDR_W-1:0] addr, output logic [BUS_DATA_W-1:0] data);
    @(posedge clk_adc_125mhz);
    bus_req.addr <= addr;
    bus_req.ren  <= 1'b1;
    @(posedge clk_adc_125mhz);
    bus_req.ren  <= 1'b0;
    @(negedge clk_adc_125mhz);
    data = bus_rsp.rdata;                                 // valid with ack
    checks++;
    assert (bus_rsp.ack) else begin
      errors++;
      $display("no bus acknowledge for the read of offset %h", addr);
    end
  endtask

  task automatic wait_tick();
    @(negedge clk_adc_125mhz);
    while (!sample_tick) @(negedge clk_adc_125mhz);
  endtask

  task automatic read_rec_pair(input string name);
    logic [31:0]  left_v, right_v;
    sample_pair_t exp;
    bus_read(REC_DATA, left_v);
    exp = (rec_q.size() > 0) ? rec_q[0] : '0;            // empty FIFO reads as 0
    check_equal({name, " left"}, exp.left, left_v);
    bus_read(REC_DATA, right_v);                          // right read pops
    check_equal({name, " right"}, exp.right, right_v);
    if (rec_q.size() > 0) void'(rec_q.pop_front());
  endtask

  // ----------------------------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------------------------
  task automatic startup_check();
    logic [31:0] st;
    repeat (STARTUP_CYCLES + 1) @(posedge clk_adc_125mhz);
    bus_read(STATUS, st);
    check_equal("startup codec ready", 1, st[CODEC_READY]);
    check_equal("startup play half empty", 1, st[PLAY_HALF_EMPTY]);
    check_equal("startup play full", 0, st[PLAY_FULL]);
    check_equal("startup play irq", 1, irq_play);         // play FIFO empty
  endtask

  task automatic tick_cadence();
    int iv [12];
    int n, w, k, longs;
    wait_tick();
    for (k = 0; k < 12; k++) begin
      n = 0;
      do begin
        @(negedge clk_adc_125mhz);
        n++;
      end while (!sample_tick);
      iv[k] = n;
      checks++;
      assert (n == CTR_MAX || n == CTR_MAX + 1) else begin
        errors++;
        $display("MISMATCH tick interval: expected %0d or %0d, actual %0d",
                 CTR_MAX, CTR_MAX + 1, n);
      end
    end
    for (w = 0; w + FRC_MAX < 12; w++) begin             // sliding window of 6 intervals
      longs = 0;
      for (k = w; k <= w + FRC_MAX; k++) begin
        if (iv[k] == CTR_MAX + 1) longs++;
      end
      check_equal("long intervals per window", 1, longs);
    end
  endtask

  task automatic playback_path();
    sample_pair_t pair;
    logic [31:0]  st;
    int           i;
    play_q.delete();
    wait_tick();                                          // whole fill fits before next tick
    bus_write(FIFO_RESET, 32'h1);                         // clears underrun too
    for (i = 0; i < 8; i++) begin
      pair = sample_pair_t'($urandom);
      if (i == 7) check_equal("play irq at 7 pairs", 1, irq_play);
      bus_write(PLAY_DATA, pair.left);
      bus_write(PLAY_DATA, pair.right);
      play_q.push_back(pair);
    end
    check_equal("play irq at 8 pairs", 0, irq_play);
    bus_read(STATUS, st);
    check_equal("play underrun after flush", 0, st[PLAY_UNDERRUN]);
    check_equal("play half empty at 8 pairs", 0, st[PLAY_HALF_EMPTY]);
    for (i = 0; i < 8; i++) begin
      wait_tick();
      @(negedge clk_adc_125mhz);                          // line out one cycle after tick
      check_equal("line out pair", play_q[i], line_out);
    end
    wait_tick();
    @(negedge clk_adc_125mhz);
    check_equal("line out held on underrun", play_q[7], line_out);
    bus_read(STATUS, st);
    check_equal("play underrun flag", 1, st[PLAY_UNDERRUN]);
  endtask

  task automatic record_path();
    logic [31:0] st;
    int          i;
    rec_model_en = 1'b0;
    bus_write(FIFO_RESET, 32'h2);
    rec_q.delete();
    rec_model_en = 1'b1;
    repeat (4) wait_tick();
    for (i = 0; i < 3; i++) read_rec_pair("record pair");
    repeat (18) wait_tick();                              // left unread until full
    bus_read(STATUS, st);
    check_equal("record full flag", 1, st[REC_FULL]);
    check_equal("record overrun flag", 1, st[REC_OVERRUN]);
    check_equal("record irq when full", 1, irq_rec);
    for (i = 0; i < FIFO_DEPTH; i++) read_rec_pair("record after overrun");
  endtask

  task automatic fifo_reset();
    logic [31:0]         st, word;
    logic [SAMPLE_W-1:0] exp_left;
    wait_tick();
    bus_read(REC_DATA, word);                             // phase now on the right sample
    exp_left = (rec_q.size() > 0) ? rec_q[0].left : '0;
    check_equal("left read before reset", exp_left, word);
    rec_model_en = 1'b0;
    bus_write(FIFO_RESET, 32'h3);
    rec_q.delete();
    rec_model_en = 1'b1;
    bus_read(STATUS, st);
    check_equal("underrun after reset", 0, st[PLAY_UNDERRUN]);
    check_equal("overrun after reset", 0, st[REC_OVERRUN]);
    check_equal("record empty after reset", 1, st[REC_EMPTY]);
    repeat (2) wait_tick();
    read_rec_pair("first read after reset");              // must start on the left sample
  endtask

  task automatic codec_mirror();
    int                  idx [4] = '{1, 17, 42, 63};
    logic [SAMPLE_W-1:0] words [4];
    logic [31:0]         st, word;
    int                  i, polls;
    for (i = 0; i < 4; i++) begin
      words[i] = SAMPLE_W'($urandom);
      bus_write(CODEC_WDATA, words[i]);
      bus_write(CODEC_ADDR, 32'(idx[i] << 1));            // bit 7 low stores
    end
    for (i = 0; i < 4; i++) begin
      bus_write(CODEC_ADDR, 32'h80 | 32'(idx[i] << 1));   // bit 7 high recalls
      polls = 0;
      st    = '0;
      while (!st[ACCESS_DONE] && polls < 10) begin
        bus_read(STATUS, st);
        polls++;
      end
      checks++;
      assert (st[ACCESS_DONE]) else begin
        errors++;
        $display("access done never set for the recall of codec index %0d", idx[i]);
      end
      bus_read(CODEC_RDATA, word);
      check_equal("codec recall data", words[i], word);
    end
  endtask

  // ----------------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------------
  initial begin
    void'($urandom(SEED));
    adc_rstn = 1'b0;
    bus_req  = '0;
    line_in  = sample_pair_t'($urandom);
    repeat (RESET_CYCLES) @(posedge clk_adc_125mhz);
    adc_rstn <= 1'b1;
    startup_check();
    tick_cadence();
    playback_path();
    record_path();
    fifo_reset();
    codec_mirror();
    @(posedge clk_adc_125mhz);
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src/ac97_codec_regs.sv
// mirror of the codec register space, store and recall through the bus decoder
`timescale 1ns/100ps
`default_nettype none

module ac97_codec_regs (
  input  logic                              clk_adc_125mhz,
  input  logic                              adc_rstn_i,
  input  logic                              store_i,
  input  logic                              recall_i,
  input  logic [ac97_pkg::CODEC_ADDR_W-1:0] index_i,
  input  logic [ac97_pkg::SAMPLE_W-1:0]     wdata_i,
  output logic [ac97_pkg::SAMPLE_W-1:0]     rdata_o,        // held between recalls
  output logic                              access_done_o,
  input  logic                              addr_write_i    // clears access done
);

  import ac97_pkg::*;

  typedef enum logic [1:0] {IDLE, RECALL1, RECALL2, DONE} state_e;

  logic [SAMPLE_W-1:0] mem [2**CODEC_ADDR_W];
  logic [SAMPLE_W-1:0] rd_s1, rd_s2;            // recall pipeline
  logic [1:0]          rcl_vld;
  state_e              state;

  always_ff @(posedge clk_adc_125mhz) begin
    if (store_i) mem[index_i] <= wdata_i;
    rd_s1 <= mem[index_i];
    rd_s2 <= rd_s1;
    if (rcl_vld[1]) rdata_o <= rd_s2;           // lands with DONE
  end

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      rcl_vld <= '0;
      state   <= IDLE;
    end else begin
      rcl_vld <= {rcl_vld[0], recall_i};        // back-to-back recalls
      if (addr_write_i) state <= recall_i ? RECALL1 : (store_i ? DONE : IDLE);
      else if (state == RECALL1) state <= RECALL2;
      else if (state == RECALL2) state <= DONE;
    end
  end

  assign access_done_o = (state == DONE);

endmodule

`default_nettype wire

// File: src/ac97_frame_port.sv
// line side of the bridge, moves one stereo pair each way per sample tick
`timescale 1ns/100ps
`default_nettype none

module ac97_frame_port #(
  parameter int TICK_CTR_MAX = 2604,
  parameter int TICK_FRC_MAX = 5
) (
  input  logic                   clk_adc_125mhz,
  input  logic                   adc_rstn_i,
  input  ac97_pkg::sample_pair_t play_head_i,
  input  logic                   play_empty_i,
  output logic                   play_pop_o,
  input  logic                   play_flush_i,
  input  ac97_pkg::sample_pair_t line_in_i,
  output logic                   rec_push_o,
  output ac97_pkg::sample_pair_t rec_data_o,
  input  logic                   rec_full_i,
  input  logic                   rec_flush_i,
  output ac97_pkg::sample_pair_t line_out_o,
  output logic                   underrun_o,
  output logic                   overrun_o,
  output logic                   sample_tick_o
);

  logic sample_tick;

  ac97_sample_tick #(
    .CTR_MAX (TICK_CTR_MAX),
    .FRC_MAX (TICK_FRC_MAX)
  ) i_sample_tick (
    .clk_adc_125mhz (clk_adc_125mhz),
    .adc_rstn_i     (adc_rstn_i),
    .sample_tick_o  (sample_tick)
  );

  assign sample_tick_o = sample_tick;
  assign play_pop_o    = sample_tick;           // FIFO drops it when empty
  assign rec_push_o    = sample_tick;           // FIFO drops it when full
  assign rec_data_o    = line_in_i;

  // ---------------------------------------------------------------------------
  // line out register and sticky run flags
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      line_out_o <= '0;
      underrun_o <= 1'b0;
      overrun_o  <= 1'b0;
    end else begin
      if (sample_tick && !play_empty_i) line_out_o <= play_head_i;
      if (play_flush_i)                    underrun_o <= 1'b0;
      else if (sample_tick && play_empty_i) underrun_o <= 1'b1;  // old pair held
      if (rec_flush_i)                     overrun_o  <= 1'b0;
      else if (sample_tick && rec_full_i)   overrun_o  <= 1'b1;  // pair lost
    end
  end

endmodule

`default_nettype wire

// File: src/ac97_sample_fifo.sv
// circular stereo-pair FIFO with fill flags and a level interrupt, one per direction
`timescale 1ns/100ps
`default_nettype none

module ac97_sample_fifo #(
  parameter int                  DEPTH     = 16,  // power of two
  parameter ac97_pkg::irq_level_e IRQ_LEVEL = ac97_pkg::NONE
) (
  input  logic                   clk_adc_125mhz,
  input  logic                   adc_rstn_i,
  input  logic                   flush_i,       // empties on the next edge
  input  logic                   push_valid_i,
  input  ac97_pkg::sample_pair_t push_data_i,
  output logic                   push_ready_o,
  input  logic                   pop_i,         // ignored when empty
  output ac97_pkg::sample_pair_t head_o,        // oldest pair
  output logic                   empty_o,
  output logic                   full_o,
  output logic                   half_empty_o,
  output logic                   irq_o
);

  import ac97_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = PTR_W + 1;

  sample_pair_t     mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr, rd_ptr;             // wrap on their own
  logic [CNT_W-1:0] count;
  logic             do_push, do_pop;

  assign push_ready_o = !full_o;
  assign do_push      = push_valid_i && push_ready_o;
  assign do_pop       = pop_i && !empty_o;
  assign head_o       = mem[rd_ptr];

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i || flush_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  always_ff @(posedge clk_adc_125mhz) begin
    if (do_push) mem[wr_ptr] <= push_data_i;
  end

  // flags straight from the counter
  assign empty_o      = (count == '0);
  assign full_o       = (count == CNT_W'(DEPTH));
  assign half_empty_o = (count < CNT_W'(DEPTH / 2));

  always_comb begin
    case (IRQ_LEVEL)
      EMPTY:      irq_o = empty_o;
      HALF_EMPTY: irq_o = half_empty_o;
      HALF_FULL:  irq_o = !half_empty_o;
      FULL:       irq_o = full_o;
      default:    irq_o = 1'b0;     // NONE
    endcase
  end

  a_count_bound : assert property (@(posedge clk_adc_125mhz) disable iff (!adc_rstn_i)
    count <= CNT_W'(DEPTH))
    else $error("FIFO count beyond depth");

endmodule

`default_nettype wire

// File: src/ac97_sample_tick.sv
// fractional clock divider, emits a one-cycle pulse at the audio sample rate
`timescale 1ns/100ps
`default_nettype none

module ac97_sample_tick #(
  parameter int CTR_MAX = 2604,        // short run length in cycles
  parameter int FRC_MAX = 5            // long run after FRC_MAX short ones
) (
  input  logic clk_adc_125mhz,
  input  logic adc_rstn_i,
  output logic sample_tick_o
);

  localparam int CTR_W = $clog2(CTR_MAX + 1);
  localparam int FRC_W = (FRC_MAX > 0) ? $clog2(FRC_MAX + 1) : 1;

  logic [CTR_W-1:0] ctr;               // cycle counter
  logic [FRC_W-1:0] frc;               // tick counter, picks the long run

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      ctr           <= '0;
      frc           <= '0;
      sample_tick_o <= 1'b0;
    end else if (ctr == CTR_W'(CTR_MAX)) begin
      sample_tick_o <= 1'b1;
      if (frc == FRC_W'(FRC_MAX)) begin
        frc <= '0;
        ctr <= '0;                     // one extra cycle
      end else begin
        frc <= frc + 1'b1;
        ctr <= CTR_W'(1);              // short run
      end
    end else begin
      sample_tick_o <= 1'b0;
      ctr           <= ctr + 1'b1;
    end
  end

  a_tick_single : assert property (@(posedge clk_adc_125mhz) disable iff (!adc_rstn_i)
    sample_tick_o |=> !sample_tick_o)
    else $error("sample tick wider than one cycle");

endmodule

`default_nettype wire

// File: src/ac97ctrl_top.sv
// top level of the audio sample bridge, ties decoder, FIFOs, line port and codec mirror
`timescale 1ns/100ps
`default_nettype none

module ac97ctrl_top #(
  parameter int                   FIFO_DEPTH     = 16,
  parameter int                   TICK_CTR_MAX   = 2604,
  parameter int                   TICK_FRC_MAX   = 5,
  parameter ac97_pkg::irq_level_e PLAY_IRQ_LEVEL = ac97_pkg::HALF_EMPTY,
  parameter ac97_pkg::irq_level_e REC_IRQ_LEVEL  = ac97_pkg::HALF_FULL
) (
  input  logic                   clk_adc_125mhz,
  input  logic                   adc_rstn_i,
  input  ac97_pkg::bus_req_t     bus_req_i,
  output ac97_pkg::bus_rsp_t     bus_rsp_o,
  input  ac97_pkg::sample_pair_t line_in_i,
  output ac97_pkg::sample_pair_t line_out_o,
  output logic                   sample_tick_o,
  output logic                   irq_play_o,
  output logic                   irq_rec_o
);

  import ac97_pkg::*;

  sample_pair_t            play_push_data, play_head, rec_data, rec_head;
  logic                    play_push_valid, play_push_ready, play_flush, rec_flush;
  logic                    play_pop, play_empty, play_full, play_half_empty;
  logic                    rec_push, rec_pop, rec_full, rec_empty;
  logic                    underrun, overrun, access_done;
  logic                    codec_store, codec_recall, codec_addr_write;
  logic [CODEC_ADDR_W-1:0] codec_index;
  logic [SAMPLE_W-1:0]     codec_wdata, codec_rdata;

  ac97_bus_regs i_bus_regs (
    .clk_adc_125mhz     (clk_adc_125mhz),   .adc_rstn_i        (adc_rstn_i),
    .bus_req_i          (bus_req_i),        .bus_rsp_o         (bus_rsp_o),
    .play_push_valid_o  (play_push_valid),  .play_push_data_o  (play_push_data),
    .play_push_ready_i  (play_push_ready),  .play_flush_o      (play_flush),
    .rec_flush_o        (rec_flush),        .rec_head_i        (rec_head),
    .rec_pop_o          (rec_pop),          .play_full_i       (play_full),
    .play_half_empty_i  (play_half_empty),  .rec_full_i        (rec_full),
    .rec_empty_i        (rec_empty),        .access_done_i     (access_done),
    .underrun_i         (underrun),         .overrun_i         (overrun),
    .codec_store_o      (codec_store),      .codec_recall_o    (codec_recall),
    .codec_addr_write_o (codec_addr_write), .codec_index_o     (codec_index),
    .codec_wdata_o      (codec_wdata),      .codec_rdata_i     (codec_rdata)
  );

  ac97_sample_fifo #(.DEPTH(FIFO_DEPTH), .IRQ_LEVEL(PLAY_IRQ_LEVEL)) i_play_fifo (
    .clk_adc_125mhz (clk_adc_125mhz),  .adc_rstn_i   (adc_rstn_i),
    .flush_i        (play_flush),      .push_valid_i (play_push_valid),
    .push_data_i    (play_push_data),  .push_ready_o (play_push_ready),
    .pop_i          (play_pop),        .head_o       (play_head),
    .empty_o        (play_empty),      .full_o       (play_full),
    .half_empty_o   (play_half_empty), .irq_o        (irq_play_o)
  );

  ac97_sample_fifo #(.DEPTH(FIFO_DEPTH), .IRQ_LEVEL(REC_IRQ_LEVEL)) i_rec_fifo (
    .clk_adc_125mhz (clk_adc_125mhz),  .adc_rstn_i   (adc_rstn_i),
    .flush_i        (rec_flush),       .push_valid_i (rec_push),
    .push_data_i    (rec_data),        .push_ready_o (),          // full seen by port
    .pop_i          (rec_pop),         .head_o       (rec_head),
    .empty_o        (rec_empty),       .full_o       (rec_full),
    .half_empty_o   (),                .irq_o        (irq_rec_o)
  );

  ac97_frame_port #(.TICK_CTR_MAX(TICK_CTR_MAX), .TICK_FRC_MAX(TICK_FRC_MAX)) i_frame_port (
    .clk_adc_125mhz (clk_adc_125mhz), .adc_rstn_i    (adc_rstn_i),
    .play_head_i    (play_head),      .play_empty_i  (play_empty),
    .play_pop_o     (play_pop),       .play_flush_i  (play_flush),
    .line_in_i      (line_in_i),      .rec_push_o    (rec_push),
    .rec_data_o     (rec_data),       .rec_full_i    (rec_full),
    .rec_flush_i    (rec_flush),      .line_out_o    (line_out_o),
    .underrun_o     (underrun),       .overrun_o     (overrun),
    .sample_tick_o  (sample_tick_o)
  );

  ac97_codec_regs i_codec_regs (
    .clk_adc_125mhz (clk_adc_125mhz), .adc_rstn_i    (adc_rstn_i),
    .store_i        (codec_store),    .recall_i      (codec_recall),
    .index_i        (codec_index),    .wdata_i       (codec_wdata),
    .rdata_o        (codec_rdata),    .access_done_o (access_done),
    .addr_write_i   (codec_addr_write)
  );

endmodule

`default_nettype wire
